// File: Bender.yml
package:
  name: cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/cpu_control.sv
  - verilog/cpu_mem_port.sv
  - verilog/cpu_decoder.sv
  - verilog/cpu_regfile.sv
  - verilog/cpu_alu.sv
  - verilog/cpu.sv
  - target: test
    files:
      - tests/tb_mem_model.sv
      - tests/tb_cpu.sv

// File: project.f
verilog/cpu_pkg.sv
verilog/cpu_control.sv
verilog/cpu_mem_port.sv
verilog/cpu_decoder.sv
verilog/cpu_regfile.sv
verilog/cpu_alu.sv
verilog/cpu.sv
tests/tb_mem_model.sv
tests/tb_cpu.sv

// File: tests/cpu_testdata.hex
// word count, program words, output byte count, output bytes,
// final x10, final word at RAM 0x1004
00000041
000302B7 00500093 FFD00113 002081B3 40208233 003211B3 00115233 00F27213
0041E1B3 04018393 00728023 40115333 00132433 FFE12493 00940433 00644413
01046413 01C35493 0014F4B3 40115313 00944433 00640433 04040393 00728023
000015B7 12345637 67860613 00C5A023 04100693 00D582A3 0045A703 00875393
00728023 0015C383 00728023 0005A783 0187D393 04038393 00728023 00258323
0065C383 0043D393 04038393 00728023 00000513 00300813 03080393 00728023
01050533 FFF80813 FE0818E3 00184463 06450513 00115463 01050513 00000463
06450513 010000EF 04050393 00728023 0002A223 00150513 F8008393 00728023
FE9FF06F
// output bytes
0000000B
0000006F 0000004F 00000041 00000056 00000052 0000004F
00000033 00000032 00000031 00000068 00000057
// final x10
00000017
// RAM word 0x1004
00FD4100

// File: tests/tb_cpu.sv
/* testbench for the RV32I subset core: runs the testdata program
   with rdy_in held high, then with random stalls, and checks results */
`timescale 1ns/1ns

module tb_cpu;
    import cpu_pkg::*;

    logic        clk_in;
    logic        rst_in;
    logic        rdy_in;
    logic [7:0]  mem_din_i;
    logic [7:0]  mem_dout_o;
    word_t       mem_addr_o;
    logic        mem_wr_o;
    word_t       dbgreg_dout_o;
    logic        halt;

    word_t       tdata [0:127];
    int unsigned n_words;
    int unsigned n_bytes;
    int unsigned limit;
    int unsigned cycle_cnt;
    int unsigned errors;
    int unsigned test_err0;
    int unsigned tests_run;
    int unsigned tests_failed;
    logic [31:0] seed;
    logic        stall_en;
    int unsigned run1_len;

    cpu cpu_i (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .rdy_in        (rdy_in),
        .mem_din_i     (mem_din_i),
        .mem_dout_o    (mem_dout_o),
        .mem_addr_o    (mem_addr_o),
        .mem_wr_o      (mem_wr_o),
        .dbgreg_dout_o (dbgreg_dout_o)
    );

    tb_mem_model mem (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .rdy_in  (rdy_in),
        .addr_i  (mem_addr_o),
        .wr_i    (mem_wr_o),
        .wdata_i (mem_dout_o),
        .rdata_o (mem_din_i),
        .halt_o  (halt)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // watchdog over both runs
    initial
    begin
        cycle_cnt = 0;
        while (limit == 0 || cycle_cnt < limit)
        begin
            @(posedge clk_in);
            cycle_cnt++;
        end
        $display("timeout: no halt write after %0d cycles", cycle_cnt);
        $display("TESTBENCH FAILED");
        $finish;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_err0)
            $display("test %-14s ok", name);
        else
        begin
            tests_failed++;
            $display("test %-14s %0d errors", name, errors - test_err0);
        end
        test_err0 = errors;
    endtask

    // program image is little-endian words from address 0
    task automatic load_memory();
        for (int i = 0; i < 131072; i++)
            mem.ram[i] = 8'h00;
        for (int w = 0; w < n_words; w++)
            for (int k = 0; k < 4; k++)
                mem.ram[4*w + k] = tdata[1 + w][8*k +: 8];
    endtask

    task automatic reset_cpu();
        rst_in = 1'b1;
        rdy_in = 1'b1;
        load_memory();
        repeat (4) @(posedge clk_in);
        #1 rst_in = 1'b0;
    endtask

    task automatic wait_halt();
        while (!halt)
        begin
            @(posedge clk_in);
            #1;
            if (stall_en)
            begin
                seed   = lcg_next(seed);
                rdy_in = (seed[31:30] != 2'b00);
            end
        end
        rdy_in = 1'b1;
    endtask

    task automatic check_output(input int first, input int last);
        for (int i = first; i <= last; i++)
        begin
            if (i >= mem.out_q.size())
            begin
                errors++;
                $display("output byte %0d was never written", i);
            end
            else
                check_byte($sformatf("out[%0d]", i), mem.out_q[i], tdata[n_words + 2 + i][7:0]);
        end
    endtask

    initial
    begin
        rst_in       = 1'b1;
        rdy_in       = 1'b1;
        errors       = 0;
        test_err0    = 0;
        tests_run    = 0;
        tests_failed = 0;
        limit        = 0;
        stall_en     = 1'b0;
        seed         = 32'hb383_aaec;
        run1_len     = 0;

        $readmemh("tests/cpu_testdata.hex", tdata);
        n_words = tdata[0];
        n_bytes = tdata[n_words + 1];
        // 64 cycles per instruction, x8 for loops, x2 for stalls, two runs
        limit = n_words * 64 * 8 * 2 * 2;

        reset_cpu();
        check_byte("mem_wr_o", {7'b0, mem_wr_o}, 8'h00);
        check_word("mem_addr_o", mem_addr_o, 32'h0);
        check_word("dbgreg_dout_o", dbgreg_dout_o, 32'h0);
        for (int k = 0; k < 4; k++)
        begin
            @(posedge clk_in);
            #1 check_word("mem_addr_o", mem_addr_o, word_t'(k));
        end
        finish_test("reset");

        wait_halt();
        // output byte groups: 0-1 ALU, 2-5 memory, rest branches
        check_output(0, 1);
        finish_test("alu_imm");

        check_output(2, 5);
        check_word("ram[0x1004]", {mem.ram[32'h1007], mem.ram[32'h1006],
                   mem.ram[32'h1005], mem.ram[32'h1004]}, tdata[n_words + 3 + n_bytes]);
        finish_test("load_store");

        check_output(6, n_bytes - 1);
        check_word("dbgreg_dout_o", dbgreg_dout_o, tdata[n_words + 2 + n_bytes]);
        finish_test("branch_jal");

        run1_len = mem.out_q.size();
        stall_en = 1'b1;
        reset_cpu();
        wait_halt();
        stall_en = 1'b0;
        check_output(0, n_bytes - 1);
        check_word("dbgreg_dout_o", dbgreg_dout_o, tdata[n_words + 2 + n_bytes]);
        finish_test("stall");

        if (run1_len != n_bytes || mem.out_q.size() != n_bytes)
        begin
            errors++;
            $display("output queue holds %0d and %0d bytes, %0d expected",
                     run1_len, mem.out_q.size(), n_bytes);
        end
        finish_test("halt");

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tests/tb_mem_model.sv
/* testbench memory: 128 KB byte RAM with one-cycle read latency,
   output byte port at 0x30000, cycle count read and halt at 0x30004 */
`timescale 1ns/1ns

module tb_mem_model (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,
    input  cpu_pkg::word_t addr_i,
    input  logic           wr_i,
    input  logic [7:0]     wdata_i,
    output logic [7:0]     rdata_o,
    output logic           halt_o
);
    import cpu_pkg::*;

    logic [7:0] ram [0:131071];
    logic [7:0] out_q [$];
    word_t      cycles;
    logic       is_io;

    // I/O window sits above the 128 KB RAM
    assign is_io = (addr_i[17:16] == 2'b11);

    initial
    begin
        rdata_o = 8'h00;
        halt_o  = 1'b0;
        cycles  = '0;
    end

    always @(posedge clk_in)
    begin
        // read data advances only on rdy_in high cycles
        if (rdy_in)
        begin
            if (!is_io)
                rdata_o <= ram[addr_i[16:0]];
            else if (addr_i[15:2] == 14'd1)
                rdata_o <= cycles[8*addr_i[1:0] +: 8];
            else
                rdata_o <= 8'h00;
        end

        if (rst_in)
        begin
            halt_o <= 1'b0;
            cycles <= '0;
            out_q.delete();
        end
        else
        begin
            cycles <= cycles + 32'd1;
            if (wr_i && rdy_in)
            begin
                if (!is_io)
                    ram[addr_i[16:0]] <= wdata_i;
                else if (addr_i == IO_BASE && wdata_i != 8'h00)
                    out_q.push_back(wdata_i);
                else if (addr_i == IO_BASE + 32'd4)
                    halt_o <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/cpu.sv
/* RV32I subset core top level: control, memory port, decoder,
   register file and ALU */
`timescale 1ns/1ns

module cpu (
    input  logic           clk_in,
    input  logic           rst_in,
    input  logic           rdy_in,
    input  logic [7:0]     mem_din_i,
    output logic [7:0]     mem_dout_o,
    output cpu_pkg::word_t mem_addr_o,
    output logic           mem_wr_o,
    output cpu_pkg::word_t dbgreg_dout_o
);
    import cpu_pkg::*;

    decoded_t  dec;
    word_t     instr_word;
    alu_op_e   alu_op;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_flag;
    mem_req_t  mem_req;
    word_t     mem_rdata;
    logic      mem_done;
    word_t     rs1_data;
    word_t     rs2_data;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    cpu_control u_control (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .instr_i      (dec),
        .alu_result_i (alu_result),
        .mem_rdata_i  (mem_rdata),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .alu_flag_i   (alu_flag),
        .mem_done_i   (mem_done),
        .instr_word_o (instr_word),
        .alu_op_o     (alu_op),
        .alu_a_o      (alu_a),
        .alu_b_o      (alu_b),
        .mem_req_o    (mem_req),
        .rf_we_o      (rf_we),
        .rf_waddr_o   (rf_waddr),
        .rf_wdata_o   (rf_wdata)
    );

    cpu_mem_port u_mem_port (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .req_i      (mem_req),
        .mem_din_i  (mem_din_i),
        .mem_dout_o (mem_dout_o),
        .mem_addr_o (mem_addr_o),
        .mem_wr_o   (mem_wr_o),
        .rdata_o    (mem_rdata),
        .done_o     (mem_done)
    );

    cpu_decoder u_decoder (
        .instr_i (instr_word),
        .dec_o   (dec)
    );

    // register reads follow the decoder during DECODE
    cpu_regfile u_regfile (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .rdy_in   (rdy_in),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .raddr1_i (dec.rs1),
        .raddr2_i (dec.rs2),
        .wdata_i  (rf_wdata),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data),
        .dbg_o    (dbgreg_dout_o)
    );

    cpu_alu u_alu (
        .op_i     (alu_op),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result),
        .flag_o   (alu_flag)
    );

endmodule

// File: verilog/cpu_alu.sv
/* ALU: arithmetic, logic, shifts, set-less-than, branch compares */
`timescale 1ns/1ns

module cpu_alu (
    input  cpu_pkg::alu_op_e op_i,
    input  cpu_pkg::word_t   a_i,
    input  cpu_pkg::word_t   b_i,
    output cpu_pkg::word_t   result_o,
    output logic             flag_o
);
    import cpu_pkg::*;

    logic [4:0] shamt;

    assign shamt = b_i[4:0];

    always_comb
    begin
        result_o = '0;
        flag_o   = 1'b0;
        case (op_i)
            ADD:    result_o = a_i + b_i;
            SUB:    result_o = a_i - b_i;
            SLL:    result_o = a_i << shamt;
            SLT:    result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            XOR:    result_o = a_i ^ b_i;
            SRL:    result_o = a_i >> shamt;
            SRA:    result_o = word_t'($signed(a_i) >>> shamt);
            OR:     result_o = a_i | b_i;
            AND:    result_o = a_i & b_i;
            PASS_B: result_o = b_i;
            // branch conditions, signed for BLT and BGE
            EQ:     flag_o = (a_i == b_i);
            NE:     flag_o = (a_i != b_i);
            LT:     flag_o = ($signed(a_i) < $signed(b_i));
            GE:     flag_o = ($signed(a_i) >= $signed(b_i));
            default: result_o = '0;
        endcase
    end

endmodule

// File: verilog/cpu_control.sv
/* control FSM: PC, instruction register, operand select,
   next PC and write-back source */
`timescale 1ns/1ns

module cpu_control (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  cpu_pkg::decoded_t  instr_i,
    input  cpu_pkg::word_t     alu_result_i,
    input  cpu_pkg::word_t     mem_rdata_i,
    input  cpu_pkg::word_t     rs1_data_i,
    input  cpu_pkg::word_t     rs2_data_i,
    input  logic               alu_flag_i,
    input  logic               mem_done_i,
    output cpu_pkg::word_t     instr_word_o,
    output cpu_pkg::alu_op_e   alu_op_o,
    output cpu_pkg::word_t     alu_a_o,
    output cpu_pkg::word_t     alu_b_o,
    output cpu_pkg::mem_req_t  mem_req_o,
    output logic               rf_we_o,
    output cpu_pkg::reg_addr_t rf_waddr_o,
    output cpu_pkg::word_t     rf_wdata_o
);
    import cpu_pkg::*;

    ctrl_state_e state;
    word_t       pc;
    word_t       ir;
    decoded_t    dec_q;
    word_t       rs1_q;
    word_t       rs2_q;
    word_t       res_q;
    word_t       load_q;
    logic        issued;
    word_t       pc_plus4;
    word_t       load_val;

    assign pc_plus4     = pc + 32'd4;
    assign instr_word_o = ir;

    // operands; JAL adds its offset to the PC
    assign alu_op_o = dec_q.alu_op;
    assign alu_a_o  = (dec_q.kind == JAL) ? pc : rs1_q;
    assign alu_b_o  = (dec_q.kind == ALU_REG || dec_q.kind == BRANCH) ? rs2_q : dec_q.imm;

    // byte loads come back zero extended from the port
    assign load_val = (dec_q.size == BYTE && !dec_q.unsigned_load) ?
                      {{24{mem_rdata_i[7]}}, mem_rdata_i[7:0]} : mem_rdata_i;

    always_comb
    begin
        mem_req_o       = '0;
        mem_req_o.start = (state == FETCH || state == MEM) && !issued;
        if (state == FETCH)
        begin
            mem_req_o.size = WORD;
            mem_req_o.addr = pc;
        end
        else
        begin
            mem_req_o.write = (dec_q.kind == STORE);
            mem_req_o.size  = dec_q.size;
            mem_req_o.addr  = res_q;
            mem_req_o.wdata = rs2_q;
        end
    end

    // x0 writes dropped here
    assign rf_we_o    = (state == WB) && dec_q.we && (dec_q.rd != '0);
    assign rf_waddr_o = dec_q.rd;

    always_comb
    begin
        case (dec_q.kind)
            LUI:     rf_wdata_o = dec_q.imm;
            JAL:     rf_wdata_o = pc_plus4;
            LOAD:    rf_wdata_o = load_q;
            default: rf_wdata_o = res_q;
        endcase
    end

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            state  <= FETCH;
            pc     <= RESET_PC;
            issued <= 1'b0;
        end
        else if (rdy_in)
        begin
            if (mem_req_o.start)
                issued <= 1'b1;
            case (state)
                FETCH:
                    if (mem_done_i)
                    begin
                        ir     <= mem_rdata_i;
                        issued <= 1'b0;
                        state  <= DECODE;
                    end
                DECODE:
                begin
                    dec_q <= instr_i;
                    rs1_q <= rs1_data_i;
                    rs2_q <= rs2_data_i;
                    state <= (instr_i.kind == ILLEGAL) ? HALTED : EXEC;
                end
                EXEC:
                begin
                    res_q <= alu_result_i;
                    case (dec_q.kind)
                        BRANCH:
                        begin
                            pc    <= alu_flag_i ? pc + dec_q.imm : pc_plus4;
                            state <= FETCH;
                        end
                        LOAD, STORE: state <= MEM;
                        default:     state <= WB;
                    endcase
                end
                MEM:
                    if (mem_done_i)
                    begin
                        issued <= 1'b0;
                        if (dec_q.kind == LOAD)
                        begin
                            load_q <= load_val;
                            state  <= WB;
                        end
                        else
                        begin
                            pc <= pc_plus4;
                            // the halt write parks the core
                            state <= (res_q == IO_BASE + 32'd4) ? HALTED : FETCH;
                        end
                    end
                WB:
                begin
                    pc    <= (dec_q.kind == JAL) ? res_q : pc_plus4;
                    state <= FETCH;
                end
                default:
                    state <= HALTED;
            endcase
        end
    end

    // one request per entry to a fetch or memory phase
    assert property (@(posedge clk_in) disable iff (rst_in)
        mem_req_o.start && rdy_in |=> !mem_req_o.start);

    // only loads and stores reach the memory phase
    assert property (@(posedge clk_in) disable iff (rst_in)
        (state == MEM) |-> (dec_q.kind == LOAD || dec_q.kind == STORE));

    // write-back only for instructions that write rd
    assert property (@(posedge clk_in) disable iff (rst_in)
        (state == WB) |-> dec_q.we);

endmodule

// File: verilog/cpu_decoder.sv
/* RV32I subset decoder: kind, ALU operation and immediates */
`timescale 1ns/1ns

module cpu_decoder (
    input  cpu_pkg::word_t    instr_i,
    output cpu_pkg::decoded_t dec_o
);
    import cpu_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb
    begin
        dec_o        = '0;
        dec_o.kind   = ILLEGAL;
        dec_o.alu_op = ADD;
        dec_o.rd     = instr_i[11:7];
        dec_o.rs1    = instr_i[19:15];
        dec_o.rs2    = instr_i[24:20];
        dec_o.size   = WORD;
        case (opcode_e'(instr_i[6:0]))
            OP_LUI:
            begin
                dec_o.kind   = LUI;
                dec_o.alu_op = PASS_B;
                dec_o.imm    = imm_u;
            end
            OP_JAL:
            begin
                dec_o.kind = JAL;
                dec_o.imm  = imm_j;
            end
            OP_BRANCH:
            begin
                dec_o.kind = BRANCH;
                dec_o.imm  = imm_b;
                case (funct3)
                    3'b000:  dec_o.alu_op = EQ;
                    3'b001:  dec_o.alu_op = NE;
                    3'b100:  dec_o.alu_op = LT;
                    3'b101:  dec_o.alu_op = GE;
                    default: dec_o.kind = ILLEGAL;
                endcase
            end
            OP_IMM:
            begin
                dec_o.kind = ALU_IMM;
                dec_o.imm  = imm_i;
                case (funct3)
                    3'b000:  dec_o.alu_op = ADD;
                    3'b010:  dec_o.alu_op = SLT;
                    3'b100:  dec_o.alu_op = XOR;
                    3'b110:  dec_o.alu_op = OR;
                    3'b111:  dec_o.alu_op = AND;
                    3'b001:
                        if (funct7 == 7'h00)
                            dec_o.alu_op = SLL;
                        else
                            dec_o.kind = ILLEGAL;
                    3'b101:
                        if (funct7 == 7'h00)
                            dec_o.alu_op = SRL;
                        else if (funct7 == 7'h20)
                            dec_o.alu_op = SRA;
                        else
                            dec_o.kind = ILLEGAL;
                    default: dec_o.kind = ILLEGAL;
                endcase
            end
            OP_REG:
            begin
                dec_o.kind = ALU_REG;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_o.alu_op = ADD;
                    {7'h20, 3'b000}: dec_o.alu_op = SUB;
                    {7'h00, 3'b001}: dec_o.alu_op = SLL;
                    {7'h00, 3'b010}: dec_o.alu_op = SLT;
                    {7'h00, 3'b100}: dec_o.alu_op = XOR;
                    {7'h00, 3'b101}: dec_o.alu_op = SRL;
                    {7'h20, 3'b101}: dec_o.alu_op = SRA;
                    {7'h00, 3'b110}: dec_o.alu_op = OR;
                    {7'h00, 3'b111}: dec_o.alu_op = AND;
                    default:         dec_o.kind = ILLEGAL;
                endcase
            end
            OP_LOAD:
            begin
                dec_o.kind = LOAD;
                dec_o.imm  = imm_i;
                if (funct3 == 3'b100)
                begin
                    dec_o.size          = BYTE;
                    dec_o.unsigned_load = 1'b1;
                end
                else if (funct3 != 3'b010)
                    dec_o.kind = ILLEGAL;
            end
            OP_STORE:
            begin
                dec_o.kind = STORE;
                dec_o.imm  = imm_s;
                if (funct3 == 3'b000)
                    dec_o.size = BYTE;
                else if (funct3 != 3'b010)
                    dec_o.kind = ILLEGAL;
            end
            default:
                dec_o.kind = ILLEGAL;
        endcase
        dec_o.we = (dec_o.kind == ALU_REG) || (dec_o.kind == ALU_IMM) ||
                   (dec_o.kind == LUI) || (dec_o.kind == JAL) || (dec_o.kind == LOAD);
    end

endmodule

// File: verilog/cpu_mem_port.sv
/* byte-serial memory sequencer: word assembly on reads,
   little-endian byte split on writes */
`timescale 1ns/1ns

module cpu_mem_port (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              rdy_in,
    input  cpu_pkg::mem_req_t req_i,
    input  logic [7:0]        mem_din_i,
    output logic [7:0]        mem_dout_o,
    output cpu_pkg::word_t    mem_addr_o,
    output logic              mem_wr_o,
    output cpu_pkg::word_t    rdata_o,
    output logic              done_o
);
    import cpu_pkg::*;

    logic        busy;
    logic        write_q;
    mem_size_e   size_q;
    word_t       base_q;
    word_t       wdata_q;
    logic [2:0]  cnt;
    logic [2:0]  cnt_nxt;
    logic [2:0]  nbytes;
    logic [1:0]  cap_lane;
    logic [23:0] rbuf;
    logic        last;

    // cnt = bytes issued before this cycle; read data trails by one
    assign nbytes   = (size_q == WORD) ? 3'd4 : 3'd1;
    assign cnt_nxt  = cnt + 3'd1;
    assign cap_lane = cnt[1:0] - 2'd1;
    assign last     = busy && (write_q ? (cnt == nbytes - 3'd1) : (cnt == nbytes));
    assign done_o   = last && rdy_in;

    // top lane straight from the pins on the final cycle
    assign rdata_o = (size_q == WORD) ? {mem_din_i, rbuf} : {24'b0, mem_din_i};

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
        begin
            busy       <= 1'b0;
            cnt        <= '0;
            mem_wr_o   <= 1'b0;
            mem_addr_o <= '0;
            mem_dout_o <= '0;
        end
        else if (rdy_in)
        begin
            if (req_i.start)
            begin
                busy       <= 1'b1;
                cnt        <= '0;
                write_q    <= req_i.write;
                size_q     <= req_i.size;
                base_q     <= req_i.addr;
                wdata_q    <= req_i.wdata;
                mem_addr_o <= req_i.addr;
                mem_wr_o   <= req_i.write;
                mem_dout_o <= req_i.wdata[7:0];
            end
            else if (busy)
            begin
                if (!write_q && cnt != 3'd0 && !last)
                    rbuf[8*cap_lane +: 8] <= mem_din_i;
                if (last)
                begin
                    busy     <= 1'b0;
                    mem_wr_o <= 1'b0;
                end
                else
                begin
                    cnt <= cnt_nxt;
                    if (cnt_nxt < nbytes)
                    begin
                        mem_addr_o <= base_q + {29'b0, cnt_nxt};
                        mem_dout_o <= wdata_q[8*cnt_nxt[1:0] +: 8];
                        mem_wr_o   <= write_q;
                    end
                    else
                        mem_wr_o <= 1'b0;
                end
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in)
        req_i.start |-> !busy);

endmodule

// File: verilog/cpu_pkg.sv
/* shared types for the RV32I subset core: words, enums, decoded
   instruction and memory request structs, address constants */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, XOR, SRL, SRA, OR, AND, PASS_B,
        EQ, NE, LT, GE
    } alu_op_e;

    typedef enum logic [2:0] {
        ALU_REG, ALU_IMM, LUI, JAL, BRANCH, LOAD, STORE, ILLEGAL
    } inst_kind_e;

    typedef enum logic {
        BYTE,
        WORD
    } mem_size_e;

    typedef struct packed {
        inst_kind_e kind;
        alu_op_e    alu_op;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        logic       we;
        mem_size_e  size;
        logic       unsigned_load;
    } decoded_t;

    typedef struct packed {
        logic      start;
        logic      write;
        mem_size_e size;
        word_t     addr;
        word_t     wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEM, WB, HALTED
    } ctrl_state_e;

    // output byte at IO_BASE, halt at IO_BASE + 4
    localparam word_t     IO_BASE  = 32'h0003_0000;
    localparam word_t     RESET_PC = 32'h0000_0000;
    localparam reg_addr_t DBG_REG  = 5'd10;

endpackage

// File: verilog/cpu_regfile.sv
/* 32 x 32 register file, x0 reads zero, debug port on x10 */
`timescale 1ns/1ns

module cpu_regfile (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               rdy_in,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    input  cpu_pkg::word_t     wdata_i,
    output cpu_pkg::word_t     rdata1_o,
    output cpu_pkg::word_t     rdata2_o,
    output cpu_pkg::word_t     dbg_o
);
    import cpu_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk_in)
    begin
        if (rst_in)
            regs <= '{default: '0};
        else if (rdy_in && we_i && waddr_i != '0)
            regs[waddr_i] <= wdata_i;
    end

    // x0 is never written so it stays zero
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];
    assign dbg_o    = regs[DBG_REG];

endmodule
